// File: divider.f
+incdir+verilog
+incdir+testbench
verilog/div_pkg.sv
verilog/div_operand_prep.sv
verilog/goldschmidt_iter.sv
verilog/div_result.sv
verilog/div_ctrl.sv
verilog/divider_top.sv
testbench/tb_divider.sv

// File: testbench/tb_divider_ref.svh
`ifndef TB_DIVIDER_REF_SVH
`define TB_DIVIDER_REF_SVH

// fibonacci lfsr x^32 + x^22 + x^2 + x + 1, one step per bit handed out
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    int          i;
    val = '0;
    for (i = 0; i < n; i++) begin
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        val    = {val[30:0], fb};
    end
    return val;
endfunction

// riscv m-extension result, funct3[0] clear means signed, funct3[1] set means remainder
function automatic logic [`DIV_OP_LN-1:0] ref_div(
    input logic [`DIV_OP_LN-1:0] a,
    input logic [`DIV_OP_LN-1:0] b,
    input logic [2:0]            f
);
    longint sa;
    longint sb;
    longint q;
    longint r;
    // divide by zero: all ones, or the dividend back
    if (b == '0) begin
        return f[1] ? a : '1;
    end
    if (!f[0]) begin
        sa = longint'($signed(a));
        sb = longint'($signed(b));
    end else begin
        sa = longint'(a);
        sb = longint'(b);
    end
    // 64-bit math, so min / -1 gives 2^31 which truncates back to the dividend
    q = sa / sb;
    r = sa % sb;
    return f[1] ? r[`DIV_OP_LN-1:0] : q[`DIV_OP_LN-1:0];
endfunction

// edges from the edge that drives start to the rise of done
function automatic int ref_latency(
    input logic [`DIV_OP_LN-1:0] a,
    input logic [`DIV_OP_LN-1:0] b,
    input logic [2:0]            f
);
    if (b == '0) begin
        return 1;
    end
    if (!f[0] && (a == {1'b1, {(`DIV_OP_LN-1){1'b0}}}) && (b == '1)) begin
        return 1;
    end
    return `DIV_NUM_ITER + 1;
endfunction

task automatic check_result(
    input string                 name,
    input logic [`DIV_OP_LN-1:0] exp,
    input logic [`DIV_OP_LN-1:0] got
);
    if (got !== exp) begin
        value_errs++;
        $display("ERR %s exp=%h got=%h", name, exp, got);
    end
endtask

task automatic check_latency(input string name, input int exp, input int got);
    if (got !== exp) begin
        value_errs++;
        $display("ERR %s exp=%h got=%h", name, exp, got);
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
        value_errs++;
        $display("ERR %s exp=%h got=%h", name, exp, got);
    end
endtask

`endif

// File: testbench/tb_divider.sv
`timescale 1ns/1ps
`include "div_cfg.svh"

module tb_divider;

    localparam int W          = `DIV_OP_LN;
    localparam int WAIT_LIMIT = 4 * (`DIV_NUM_ITER + 1) + 8;

    logic         clk;
    logic         rst_n;
    logic [W-1:0] op1;
    logic [W-1:0] op2;
    logic [2:0]   funct3;
    logic         start;
    logic         ack;
    logic [W-1:0] result;
    logic         done;

    // expectations of accepted operations, oldest first
    logic [W-1:0] exp_q[$];
    int           lat_q[$];
    int           edge_q[$];
    int           issued;
    int           n_done;
    int           edge_cnt;
    logic         done_q;
    logic [31:0]  lfsr_q;
    int           value_errs;
    int           timeout_errs;
    int           proto_errs;

    `include "tb_divider_ref.svh"

    divider_top DUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .op1    (op1),
        .op2    (op2),
        .funct3 (funct3),
        .start  (start),
        .ack    (ack),
        .result (result),
        .done   (done)
    );

    always #50 clk = ~clk;

    // edge index, stable at every falling edge
    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    // compare process, one check per rising done
    always @(negedge clk) begin : compare
        logic [W-1:0] exp_val;
        int           exp_lat;
        int           t0;
        if (rst_n && done && !done_q) begin
            if (exp_q.size() == 0) begin
                proto_errs++;
                $display("done rose with no accepted operation pending");
            end else begin
                exp_val = exp_q.pop_front();
                exp_lat = lat_q.pop_front();
                t0      = edge_q.pop_front();
                check_result("result", exp_val, result);
                check_latency("latency", exp_lat, edge_cnt - t0);
                n_done++;
            end
        end
        done_q = done;
    end

    // one start pulse, optionally with ack in the same cycle
    task automatic pulse_start(input logic [W-1:0] a, input logic [W-1:0] b,
                               input logic [2:0] f, input bit accepted, input bit with_ack);
        @(posedge clk);
        op1    <= a;
        op2    <= b;
        funct3 <= f;
        start  <= 1'b1;
        if (with_ack) begin
            ack <= 1'b1;
        end
        @(negedge clk);
        if (accepted) begin
            exp_q.push_back(ref_div(a, b, f));
            lat_q.push_back(ref_latency(a, b, f));
            // start was driven on the edge just counted
            edge_q.push_back(edge_cnt);
            issued++;
        end
        @(posedge clk);
        start <= 1'b0;
        ack   <= 1'b0;
        // operands only need to be valid with start
        op1    <= ~a;
        op2    <= rand_bits(W);
        funct3 <= ~f;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while ((n_done != issued) && (n < WAIT_LIMIT)) begin
            @(posedge clk);
            n++;
        end
        if (n_done != issued) begin
            timeout_errs++;
            $display("timeout: done did not rise within %0d cycles", WAIT_LIMIT);
            // drop stale expectations so later operations line up again
            exp_q.delete();
            lat_q.delete();
            edge_q.delete();
            issued = n_done;
        end
    endtask

    // withhold ack, done and result must not move, a stray start must be ignored
    task automatic hold_and_ack(input int delay, input bit stray);
        logic [W-1:0] held;
        int           i;
        @(negedge clk);
        held = result;
        for (i = 0; i < delay; i++) begin
            @(posedge clk);
            if (stray && (i == 1)) begin
                start  <= 1'b1;
                op1    <= rand_bits(W);
                op2    <= rand_bits(W) | 32'h1;
                funct3 <= {1'b1, 2'(rand_bits(2))};
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
            check_flag("done", 1'b1, done);
            check_result("result", held, result);
        end
        @(posedge clk);
        start <= 1'b0;
        ack   <= 1'b1;
        @(posedge clk);
        ack <= 1'b0;
    endtask

    task automatic run_op(input logic [W-1:0] a, input logic [W-1:0] b, input logic [2:0] f);
        pulse_start(a, b, f, 1'b1, 1'b0);
        wait_done();
        hold_and_ack(rand_bits(3), 1'b0);
    endtask

    initial begin
        int           k;
        int           fn;
        logic [2:0]   f;
        logic [W-1:0] a;
        logic [W-1:0] b;
        clk          = 1'b0;
        rst_n        = 1'b0;
        op1          = '0;
        op2          = '0;
        funct3       = '0;
        start        = 1'b0;
        ack          = 1'b0;
        lfsr_q       = 32'd30;
        issued       = 0;
        n_done       = 0;
        edge_cnt     = 0;
        done_q       = 1'b0;
        value_errs   = 0;
        timeout_errs = 0;
        proto_errs   = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag("done", 1'b0, done);
        check_result("result", '0, result);

        // random operands, divisor size varied by a random right shift
        for (fn = 0; fn < 4; fn++) begin
            for (k = 0; k < 10; k++) begin
                f = {1'b1, 2'(fn)};
                a = rand_bits(W);
                b = rand_bits(W) >> rand_bits(5);
                run_op(a, b, f);
            end
        end

        // zero divisor and signed overflow, both fast paths and unsigned twins
        for (fn = 0; fn < 4; fn++) begin
            f = {1'b1, 2'(fn)};
            run_op(rand_bits(W), '0, f);
            run_op({1'b1, {(W-1){1'b0}}}, '1, f);
        end

        // stray start during iterate, then another while the result waits
        pulse_start(rand_bits(W), rand_bits(16) | 32'h3, 3'b100, 1'b1, 1'b0);
        repeat (2) @(posedge clk);
        pulse_start(rand_bits(W), rand_bits(W) | 32'h1, 3'b101, 1'b0, 1'b0);
        wait_done();
        hold_and_ack(3 + rand_bits(3), 1'b1);

        // ack and the next start in one cycle
        pulse_start(rand_bits(W), rand_bits(20) | 32'h1, 3'b101, 1'b1, 1'b0);
        wait_done();
        pulse_start(rand_bits(W), rand_bits(12) | 32'h1, 3'b110, 1'b1, 1'b1);
        wait_done();
        hold_and_ack(rand_bits(3), 1'b0);

        // powers of two as divisor
        for (k = 0; k < W; k++) begin
            run_op(rand_bits(W), 32'h1 << k, {1'b1, 2'(k)});
        end

        // equal operands, small over large, extremes of the unsigned range
        for (fn = 0; fn < 4; fn++) begin
            f = {1'b1, 2'(fn)};
            a = rand_bits(W) | 32'h1;
            run_op(a, a, f);
            run_op(rand_bits(8), rand_bits(8) | 32'h100, f);
            run_op('1, '1, f);
            run_op('1, 32'h1, f);
            run_op('1, 32'hffff_fffe, f);
            run_op(32'h7fff_ffff, '1, f);
        end

        repeat (WAIT_LIMIT) @(posedge clk);
        if (exp_q.size() != 0) begin
            proto_errs++;
            $display("%0d accepted operations never completed", exp_q.size());
        end
        $display("errors: value=%0d timeout=%0d protocol=%0d, operations=%0d",
                 value_errs, timeout_errs, proto_errs, n_done);
        if ((value_errs + timeout_errs + proto_errs) == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/divider_top.sv
`timescale 1ns/1ps
`include "div_cfg.svh"

module divider_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`DIV_OP_LN-1:0] op1,
    input  logic [`DIV_OP_LN-1:0] op2,
    input  logic [2:0]            funct3,
    input  logic                  start,
    input  logic                  ack,
    output logic [`DIV_OP_LN-1:0] result,
    output logic                  done
);

    // decoded operands
    div_pkg::div_fn_t                 div_fn;
    div_pkg::div_case_t               div_case;
    logic [`DIV_OP_LN-1:0]            op1_abs;
    logic [`DIV_OP_LN-1:0]            op2_abs;
    logic                             op1_neg;
    logic                             op2_neg;
    logic [`DIV_OP_LN+`DIV_XP_LN-1:0] x_init;
    logic [`DIV_SH_LN-1:0]            shift_init;

    // iteration output and control strobes
    logic [`DIV_OP_LN-1:0]            quo_trial;
    logic                             load;
    logic                             finish_fast;
    logic                             finish_calc;

    div_operand_prep u_prep (
        .op1        (op1),
        .op2        (op2),
        .funct3     (funct3),
        .div_fn     (div_fn),
        .div_case   (div_case),
        .op1_abs    (op1_abs),
        .op2_abs    (op2_abs),
        .op1_neg    (op1_neg),
        .op2_neg    (op2_neg),
        .x_init     (x_init),
        .shift_init (shift_init)
    );

    goldschmidt_iter u_iter (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load),
        .op1_abs    (op1_abs),
        .x_init     (x_init),
        .shift_init (shift_init),
        .quo_trial  (quo_trial)
    );

    div_result u_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .load        (load),
        .finish_fast (finish_fast),
        .finish_calc (finish_calc),
        .div_fn      (div_fn),
        .div_case    (div_case),
        .op1         (op1),
        .op1_abs     (op1_abs),
        .op2_abs     (op2_abs),
        .op1_neg     (op1_neg),
        .op2_neg     (op2_neg),
        .quo_trial   (quo_trial),
        .result      (result)
    );

    div_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .ack         (ack),
        .div_case    (div_case),
        .load        (load),
        .finish_fast (finish_fast),
        .finish_calc (finish_calc),
        .done        (done)
    );

endmodule

// File: verilog/div_ctrl.sv
`timescale 1ns/1ps
`include "div_cfg.svh"

module div_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic               ack,
    input  div_pkg::div_case_t div_case,
    output logic               load,
    output logic               finish_fast,
    output logic               finish_calc,
    output logic               done
);
    import div_pkg::*;

    localparam CNT_LN = $clog2(`DIV_NUM_ITER + 1);

    div_state_t        state_q;
    div_state_t        state_nxt;
    logic [CNT_LN-1:0] cnt_q;
    logic [CNT_LN-1:0] cnt_nxt;
    logic              done_nxt;
    logic              waiting;
    logic              accept;

    // a finished result nobody has taken yet
    assign waiting = done && !ack;

    // same-cycle ack frees the slot for the new start
    assign accept = (state_q == IDLE) && start && !waiting;

    assign load        = accept;
    assign finish_fast = accept && (div_case != NORMAL);
    assign finish_calc = (state_q == CALC_REM);

    always_comb begin
        state_nxt = state_q;
        cnt_nxt   = cnt_q;
        case (state_q)
            IDLE: begin
                // load cycle already counts as the first iteration
                if (accept && (div_case == NORMAL)) begin
                    state_nxt = ITERATE;
                    cnt_nxt   = CNT_LN'(1);
                end
            end
            ITERATE: begin
                if (cnt_q == CNT_LN'(`DIV_NUM_ITER - 1)) begin
                    state_nxt = CALC_REM;
                end else begin
                    cnt_nxt = cnt_q + 1'b1;
                end
            end
            CALC_REM: begin
                state_nxt = IDLE;
                cnt_nxt   = '0;
            end
            default: begin
                state_nxt = IDLE;
                cnt_nxt   = '0;
            end
        endcase
    end

    // done holds until ack, or rises with a finish strobe
    assign done_nxt = waiting || finish_fast || finish_calc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            done    <= 1'b0;
        end else begin
            state_q <= state_nxt;
            cnt_q   <= cnt_nxt;
            done    <= done_nxt;
        end
    end

    // a pending result is never overwritten
    a_no_load_while_waiting: assert property (
        @(posedge clk) disable iff (!rst_n)
        (done && !ack) |-> !(load || finish_calc)
    );

    // only one operation in flight
    a_done_in_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> (state_q == IDLE)
    );

endmodule

// File: verilog/div_result.sv
`timescale 1ns/1ps
`include "div_cfg.svh"

module div_result (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load,
    input  logic                  finish_fast,
    input  logic                  finish_calc,
    input  div_pkg::div_fn_t      div_fn,
    input  div_pkg::div_case_t    div_case,
    input  logic [`DIV_OP_LN-1:0] op1,
    input  logic [`DIV_OP_LN-1:0] op1_abs,
    input  logic [`DIV_OP_LN-1:0] op2_abs,
    input  logic                  op1_neg,
    input  logic                  op2_neg,
    input  logic [`DIV_OP_LN-1:0] quo_trial,
    output logic [`DIV_OP_LN-1:0] result
);
    import div_pkg::*;

    localparam OP_LN = `DIV_OP_LN;
    // room for quotient times divisor plus a sign
    localparam RW = 2 * `DIV_OP_LN + 2;

    div_fn_t              fn_q;
    logic                 op1_neg_q;
    logic                 op2_neg_q;
    logic [OP_LN-1:0]     op1_abs_q;
    logic [OP_LN-1:0]     op2_abs_q;
    logic [2*OP_LN-1:0]   prod;
    logic signed [RW-1:0] dvd_w;
    logic signed [RW-1:0] dvs_w;
    logic signed [RW-1:0] rem_trial;
    logic signed [RW-1:0] rem_fix;
    logic [OP_LN-1:0]     quo_fix;
    logic [OP_LN-1:0]     quo_out;
    logic [OP_LN-1:0]     rem_out;
    logic [OP_LN-1:0]     calc_val;
    logic [OP_LN-1:0]     fast_val;
    logic                 live_is_quo;

    // operation context, kept until the iteration ends
    always_ff @(posedge clk) begin
        if (load) begin
            fn_q      <= div_fn;
            op1_neg_q <= op1_neg;
            op2_neg_q <= op2_neg;
            op1_abs_q <= op1_abs;
            op2_abs_q <= op2_abs;
        end
    end

    // trial remainder n - q*d in a wide signed width
    assign prod      = quo_trial * op2_abs_q;
    assign dvd_w     = $signed({{(RW-OP_LN){1'b0}}, op1_abs_q});
    assign dvs_w     = $signed({{(RW-OP_LN){1'b0}}, op2_abs_q});
    assign rem_trial = dvd_w - $signed({2'b00, prod});

    // pull the quotient back into range by one step either way
    always_comb begin
        quo_fix = quo_trial;
        rem_fix = rem_trial;
        if (rem_trial < 0) begin
            quo_fix = quo_trial - 1'b1;
            rem_fix = rem_trial + dvs_w;
        end else if (rem_trial >= dvs_w) begin
            quo_fix = quo_trial + 1'b1;
            rem_fix = rem_trial - dvs_w;
        end
    end

    // quotient negative when the signs differ, remainder follows the dividend
    assign quo_out  = (op1_neg_q ^ op2_neg_q) ? -quo_fix : quo_fix;
    assign rem_out  = op1_neg_q ? -rem_fix[OP_LN-1:0] : rem_fix[OP_LN-1:0];
    assign calc_val = ((fn_q == DIV) || (fn_q == DIVU)) ? quo_out : rem_out;

    // special values come from the live operands
    assign live_is_quo = (div_fn == DIV) || (div_fn == DIVU);

    always_comb begin
        case (div_case)
            DIV0:    fast_val = live_is_quo ? '1 : op1;
            OVFL:    fast_val = live_is_quo ? op1 : '0;
            default: fast_val = '0;
        endcase
    end

    // result holds until the next finish strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (finish_fast) begin
            result <= fast_val;
        end else if (finish_calc) begin
            result <= calc_val;
        end
    end

    // iteration plus one correction step yields an exact remainder
    a_rem_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        finish_calc |-> ((rem_fix >= 0) && (rem_fix < dvs_w))
    );

endmodule

// File: verilog/goldschmidt_iter.sv
`timescale 1ns/1ps
`include "div_cfg.svh"

module goldschmidt_iter (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             load,
    input  logic [`DIV_OP_LN-1:0]            op1_abs,
    input  logic [`DIV_OP_LN+`DIV_XP_LN-1:0] x_init,
    input  logic [`DIV_SH_LN-1:0]            shift_init,
    output logic [`DIV_OP_LN-1:0]            quo_trial
);

    // calculation width, operand plus extra fraction bits
    localparam C_LN  = `DIV_OP_LN + `DIV_XP_LN;
    localparam SH_LN = `DIV_SH_LN;
    localparam ST_LN = $clog2(`DIV_NUM_ITER + 1);

    logic [C_LN-1:0]   x_q;
    logic [C_LN-1:0]   num_q;
    logic [SH_LN-1:0]  shift_q;
    logic [ST_LN-1:0]  steps_q;
    logic              step;
    logic [C_LN-1:0]   x_cur;
    logic [C_LN-1:0]   num_cur;
    logic [SH_LN-1:0]  shift_cur;
    logic [2*C_LN-1:0] x_sq;
    logic [C_LN:0]     mul_factor;
    logic [2*C_LN:0]   num_prod;
    logic              carry;
    logic [C_LN-1:0]   num_nxt;
    logic [C_LN:0]     num_ext;
    logic [C_LN:0]     half_m1;
    logic [C_LN:0]     num_rnd;
    logic [C_LN:0]     quo_wide;

    // remaining steps after the one taken on load
    assign step = (steps_q != '0);

    // first step works on the fresh operands
    assign x_cur     = load ? x_init : x_q;
    assign num_cur   = load ? {op1_abs, {`DIV_XP_LN{1'b0}}} : num_q;
    assign shift_cur = load ? shift_init : shift_q;

    // next term x^(2^(k+1)), keeping the top fraction bits
    assign x_sq = x_cur * x_cur;

    // numerator times (1 + x^(2^k))
    assign mul_factor = {1'b1, x_cur};
    assign num_prod   = num_cur * mul_factor;

    // product crossed 1.0 so halve it and shift one less at the end
    assign carry   = num_prod[2*C_LN];
    assign num_nxt = carry ? num_prod[2*C_LN:C_LN+1] : num_prod[2*C_LN-1:C_LN];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            steps_q <= '0;
            shift_q <= '0;
        end else begin
            if (load) begin
                steps_q <= ST_LN'(`DIV_NUM_ITER - 1);
            end else if (step) begin
                steps_q <= steps_q - 1'b1;
            end
            if (load || step) begin
                shift_q <= shift_cur - SH_LN'(carry);
            end
        end
    end

    // iteration datapath, frozen once the steps run out
    always_ff @(posedge clk) begin
        if (load || step) begin
            x_q   <= x_sq[2*C_LN-1:C_LN];
            num_q <= num_nxt;
        end
    end

    // round half to even at the final shift position
    // one spare top bit absorbs the rounding carry
    assign num_ext  = {1'b0, num_q};
    assign half_m1  = ((C_LN+1)'(1) << (shift_q - 1'b1)) - 1'b1;
    assign num_rnd  = num_ext + half_m1 + (C_LN+1)'(num_ext[shift_q]);
    assign quo_wide = num_rnd >> shift_q;

    // trial magnitude, within one of the exact quotient
    assign quo_trial = quo_wide[`DIV_OP_LN-1:0];

    // pending shift stays at least one so rounding has a half bit
    a_shift_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        (load || step) |-> (shift_cur > SH_LN'(carry))
    );

endmodule

// File: verilog/div_operand_prep.sv
`timescale 1ns/1ps
`include "div_cfg.svh"

module div_operand_prep (
    input  logic [`DIV_OP_LN-1:0]            op1,
    input  logic [`DIV_OP_LN-1:0]            op2,
    input  logic [2:0]                       funct3,
    output div_pkg::div_fn_t                 div_fn,
    output div_pkg::div_case_t               div_case,
    output logic [`DIV_OP_LN-1:0]            op1_abs,
    output logic [`DIV_OP_LN-1:0]            op2_abs,
    output logic                             op1_neg,
    output logic                             op2_neg,
    output logic [`DIV_OP_LN+`DIV_XP_LN-1:0] x_init,
    output logic [`DIV_SH_LN-1:0]            shift_init
);
    import div_pkg::*;

    localparam OP_LN = `DIV_OP_LN;
    localparam HB_LN = $clog2(`DIV_OP_LN);
    localparam SH_LN = `DIV_SH_LN;

    logic             is_signed;
    logic [HB_LN-1:0] hb_chain [0:OP_LN];
    logic [HB_LN-1:0] hb_idx;
    logic [OP_LN-1:0] d_norm;
    logic [OP_LN-1:0] x_frac;

    // low two bits of funct3 map straight onto the function enum
    assign div_fn    = div_fn_t'(funct3[1:0]);
    assign is_signed = (div_fn == DIV) || (div_fn == REM);

    // signs only count for the signed functions
    assign op1_neg = is_signed & op1[OP_LN-1];
    assign op2_neg = is_signed & op2[OP_LN-1];

    // magnitudes, the most negative value maps onto itself as unsigned
    assign op1_abs = op1_neg ? -op1 : op1;
    assign op2_abs = op2_neg ? -op2 : op2;

    // leading-one search over the divisor magnitude
    // scanning upward so the highest set bit wins
    assign hb_chain[0] = '0;
    for (genvar i = 0; i < OP_LN; i++) begin : g_hb
        assign hb_chain[i+1] = op2_abs[i] ? HB_LN'(i) : hb_chain[i];
    end
    assign hb_idx = hb_chain[OP_LN];

    // divisor with its top bit just below the binary point, value in [0.5, 1)
    assign d_norm = op2_abs << (HB_LN'(OP_LN - 1) - hb_idx);

    // x = 1 - d, so 1/d is the product of (1 + x^(2^k))
    assign x_frac = -d_norm;
    assign x_init = {x_frac, {`DIV_XP_LN{1'b0}}};

    // undo the normalization and drop the extra fraction bits at the end
    assign shift_init = SH_LN'(hb_idx) + SH_LN'(`DIV_XP_LN + 1);

    // riscv special cases
    always_comb begin
        if (op2 == '0) begin
            div_case = DIV0;
        end else if (is_signed && (op1 == {1'b1, {(OP_LN-1){1'b0}}}) && (op2 == '1)) begin
            div_case = OVFL;
        end else begin
            div_case = NORMAL;
        end
    end

endmodule

// File: verilog/div_pkg.sv
package div_pkg;

    // operation selected by funct3[1:0]
    typedef enum logic [1:0] {
        DIV,
        DIVU,
        REM,
        REMU
    } div_fn_t;

    // special cases that bypass the iteration
    typedef enum logic [1:0] {
        NORMAL,
        DIV0,
        OVFL
    } div_case_t;

    // controller states
    typedef enum logic [1:0] {
        IDLE,
        ITERATE,
        CALC_REM
    } div_state_t;

endpackage

// File: verilog/div_cfg.svh
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// operand and result width
`define DIV_OP_LN 32

// goldschmidt steps, 5 reach 32-bit precision before correction
`define DIV_NUM_ITER 5

// extra fraction bits carried through the iteration, at least 1
`define DIV_XP_LN 4

// width of the pending normalization shift, derived from the above
`define DIV_SH_LN $clog2(`DIV_OP_LN + `DIV_XP_LN + 1)

`endif
